//--- verilog/memPkg.sv
`default_nettype none

package memPkg;

    // ####################
    // Bus geometry.
    parameter int dataWidth   = 32;
    parameter int strobeWidth = dataWidth / 8;

    // Access size, same coding as the load/store type field of the pipeline.
    typedef enum logic [1:0] {
        accByte = 2'b00,
        accHalf = 2'b01,
        accWord = 2'b10
    } accessType;

    // ####################
    // AXI response codes.
    parameter logic [1:0] respOkay   = 2'b00;
    parameter logic [1:0] respSlvErr = 2'b10;

endpackage

`default_nettype wire

//--- verilog/axiLiteIf.sv
`timescale 1ns/1ps
`default_nettype none

interface axiLiteIf #(
    parameter int addrWidth = 12
);
    logic                             awValid;
    logic                             awReady;
    logic [addrWidth-1:0]             awAddr;

    logic                             wValid;
    logic                             wReady;
    logic [memPkg::dataWidth-1:0]     wData;
    logic [memPkg::strobeWidth-1:0]   wStrb;

    logic                             bValid;
    logic                             bReady;
    logic [1:0]                       bResp;

    logic                             arValid;
    logic                             arReady;
    logic [addrWidth-1:0]             arAddr;

    logic                             rValid;
    logic                             rReady;
    logic [memPkg::dataWidth-1:0]     rData;
    logic [1:0]                       rResp;

    modport master (
        output awValid, awAddr, wValid, wData, wStrb, bReady, arValid, arAddr, rReady,
        input  awReady, wReady, bValid, bResp, arReady, rValid, rData, rResp
    );

    modport slave (
        input  awValid, awAddr, wValid, wData, wStrb, bReady, arValid, arAddr, rReady,
        output awReady, wReady, bValid, bResp, arReady, rValid, rData, rResp
    );

endinterface

`default_nettype wire

//--- verilog/memStage.sv
`timescale 1ns/1ps
`default_nettype none

module memStage #(
    parameter int addrWidth = 12
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          reqValid,
    output logic                          reqReady,
    input  logic                          reqWrite,
    input  memPkg::accessType             reqType,
    input  logic                          reqUnsigned,
    input  logic [addrWidth-1:0]          reqAddr,
    input  logic [memPkg::dataWidth-1:0]  reqData,
    output logic                          respValid,
    input  logic                          respReady,
    output logic [memPkg::dataWidth-1:0]  respData,
    output logic                          respError,
    axiLiteIf.master                      bus
);

    typedef enum logic [2:0] {
        stIdle,
        stWrite,
        stWriteResp,
        stRead,
        stReadResp,
        stDone
    } stateType;

    stateType                        state;
    memPkg::accessType               accType;
    logic                            isUnsigned;
    logic [addrWidth-1:0]            addr;
    logic [memPkg::dataWidth-1:0]    storeData;
    logic                            misaligned;
    logic [memPkg::strobeWidth-1:0]  strobe;
    logic [memPkg::dataWidth-1:0]    laneData;
    logic [memPkg::dataWidth-1:0]    loadWord;
    logic [memPkg::dataWidth-1:0]    loadData;

    always_comb
    begin
        case (reqType)
            memPkg::accByte: misaligned = 1'b0;
            memPkg::accHalf: misaligned = reqAddr[0];
            default:         misaligned = |reqAddr[1:0];
        endcase
    end

    // ####################
    // Store side: lane strobes and shifted data.
    always_comb
    begin
        case (accType)
            memPkg::accByte:
            begin
                strobe   = 4'b0001 << addr[1:0];
                laneData = {24'b0, storeData[7:0]} << {addr[1:0], 3'b000};
            end
            memPkg::accHalf:
            begin
                strobe   = 4'b0011 << addr[1:0]; // Bit 0 is clear here.
                laneData = {16'b0, storeData[15:0]} << {addr[1:0], 3'b000};
            end
            default:
            begin
                strobe   = 4'b1111;
                laneData = storeData;
            end
        endcase
    end

    // Load side: bring the addressed lane down and extend it.
    assign loadWord = bus.rData >> {addr[1:0], 3'b000};

    always_comb
    begin
        case (accType)
            memPkg::accByte: loadData = {{24{loadWord[7] & ~isUnsigned}}, loadWord[7:0]};
            memPkg::accHalf: loadData = {{16{loadWord[15] & ~isUnsigned}}, loadWord[15:0]};
            default:         loadData = bus.rData;
        endcase
    end

    // ####################
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= stIdle;
            respError <= 1'b0;
        end
        else
        begin
            case (state)
                stIdle:
                    if (reqValid)
                    begin
                        respError <= misaligned; // Never goes out on the bus.
                        if (misaligned)
                            state <= stDone;
                        else if (reqWrite)
                            state <= stWrite;
                        else
                            state <= stRead;
                    end
                stWrite:
                    if (bus.awReady && bus.wReady)
                        state <= stWriteResp;
                stWriteResp:
                    if (bus.bValid)
                    begin
                        respError <= (bus.bResp != memPkg::respOkay);
                        state     <= stDone;
                    end
                stRead:
                    if (bus.arReady)
                        state <= stReadResp;
                stReadResp:
                    if (bus.rValid)
                    begin
                        respError <= (bus.rResp != memPkg::respOkay);
                        state     <= stDone;
                    end
                stDone:
                    if (respReady)
                        state <= stIdle;
                default:
                    state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == stIdle && reqValid)
        begin
            accType    <= reqType;
            isUnsigned <= reqUnsigned;
            addr       <= reqAddr;
            storeData  <= reqData;
        end
        if (state == stReadResp && bus.rValid)
            respData <= loadData;
    end

    assign reqReady    = (state == stIdle);
    assign respValid   = (state == stDone);
    assign bus.awValid = (state == stWrite);
    assign bus.wValid  = (state == stWrite); // Address and data go together.
    assign bus.awAddr  = {addr[addrWidth-1:2], 2'b00};
    assign bus.wData   = laneData;
    assign bus.wStrb   = strobe;
    assign bus.bReady  = (state == stWriteResp);
    assign bus.arValid = (state == stRead);
    assign bus.arAddr  = {addr[addrWidth-1:2], 2'b00};
    assign bus.rReady  = (state == stReadResp);

    strobeLegal: assert property (@(posedge clk) disable iff (rst)
        bus.wValid |-> bus.wStrb inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                         4'b0011, 4'b1100, 4'b1111})
        else $error("memStage: illegal write strobe %b", bus.wStrb);

endmodule

`default_nettype wire

//--- verilog/fetchPort.sv
`timescale 1ns/1ps
`default_nettype none

module fetchPort #(
    parameter int addrWidth = 12
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          fetchValid,
    output logic                          fetchReady,
    input  logic [addrWidth-1:0]          fetchAddr,
    output logic                          fetchRespValid,
    input  logic                          fetchRespReady,
    output logic [memPkg::dataWidth-1:0]  fetchInstr,
    output logic                          fetchError,
    axiLiteIf.master                      bus
);

    typedef enum logic [1:0] {
        stIdle,
        stRead,
        stReadResp,
        stDone
    } stateType;

    stateType              state;
    logic [addrWidth-1:0]  pc;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= stIdle;
            fetchError <= 1'b0;
        end
        else
        begin
            case (state)
                stIdle:
                    if (fetchValid)
                    begin
                        fetchError <= |fetchAddr[1:0];
                        state      <= (|fetchAddr[1:0]) ? stDone : stRead;
                    end
                stRead:
                    if (bus.arReady)
                        state <= stReadResp;
                stReadResp:
                    if (bus.rValid)
                    begin
                        fetchError <= (bus.rResp != memPkg::respOkay);
                        state      <= stDone;
                    end
                default:
                    if (fetchRespReady)
                        state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == stIdle && fetchValid)
            pc <= fetchAddr;
        if (state == stReadResp && bus.rValid)
            fetchInstr <= bus.rData; // Held until the consumer takes it.
    end

    assign fetchReady     = (state == stIdle);
    assign fetchRespValid = (state == stDone);
    assign bus.arValid    = (state == stRead);
    assign bus.arAddr     = pc;
    assign bus.rReady     = (state == stReadResp);

    // Instruction reads only.
    assign bus.awValid = 1'b0;
    assign bus.awAddr  = '0;
    assign bus.wValid  = 1'b0;
    assign bus.wData   = '0;
    assign bus.wStrb   = '0;
    assign bus.bReady  = 1'b0;

endmodule

`default_nettype wire

//--- verilog/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter #(
    parameter int addrWidth = 12
) (
    input  logic      clk,
    input  logic      rst,
    axiLiteIf.slave   dataSide,
    axiLiteIf.slave   fetchSide,
    axiLiteIf.master  ram
);

    logic                  ownerValid;
    logic                  ownerFetch;
    logic                  prioFetch; // Low after reset, so memStage wins first.
    logic                  dataReq;
    logic                  fetchReq;
    logic                  grantFetch;
    logic                  ownerDone;
    logic                  selData;
    logic                  selFetch;
    logic [addrWidth-1:0]  awAddrSel;
    logic [addrWidth-1:0]  arAddrSel;

    assign dataReq    = dataSide.awValid | dataSide.arValid;
    assign fetchReq   = fetchSide.awValid | fetchSide.arValid;
    assign grantFetch = fetchReq & (prioFetch | ~dataReq);
    assign ownerDone  = (ram.bValid & ram.bReady) | (ram.rValid & ram.rReady);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            ownerValid <= 1'b0;
            ownerFetch <= 1'b0;
            prioFetch  <= 1'b0;
        end
        else if (!ownerValid)
        begin
            if (dataReq || fetchReq)
            begin
                ownerValid <= 1'b1;
                ownerFetch <= grantFetch;
            end
        end
        else if (ownerDone)
        begin
            ownerValid <= 1'b0; // Idle for one cycle.
            prioFetch  <= ~ownerFetch;
        end
    end

    assign selData  = ownerValid & ~ownerFetch;
    assign selFetch = ownerValid & ownerFetch;

    // ####################
    // Owner's requests toward the RAM.
    assign awAddrSel   = ownerFetch ? fetchSide.awAddr : dataSide.awAddr;
    assign arAddrSel   = ownerFetch ? fetchSide.arAddr : dataSide.arAddr;
    assign ram.awValid = (selData & dataSide.awValid) | (selFetch & fetchSide.awValid);
    assign ram.awAddr  = awAddrSel;
    assign ram.wValid  = (selData & dataSide.wValid) | (selFetch & fetchSide.wValid);
    assign ram.wData   = ownerFetch ? fetchSide.wData : dataSide.wData;
    assign ram.wStrb   = ownerFetch ? fetchSide.wStrb : dataSide.wStrb;
    assign ram.bReady  = (selData & dataSide.bReady) | (selFetch & fetchSide.bReady);
    assign ram.arValid = (selData & dataSide.arValid) | (selFetch & fetchSide.arValid);
    assign ram.arAddr  = arAddrSel;
    assign ram.rReady  = (selData & dataSide.rReady) | (selFetch & fetchSide.rReady);

    // ####################
    // RAM answers, the other side sees nothing.
    assign dataSide.awReady = selData & ram.awReady;
    assign dataSide.wReady  = selData & ram.wReady;
    assign dataSide.bValid  = selData & ram.bValid;
    assign dataSide.bResp   = ram.bResp;
    assign dataSide.arReady = selData & ram.arReady;
    assign dataSide.rValid  = selData & ram.rValid;
    assign dataSide.rData   = ram.rData;
    assign dataSide.rResp   = ram.rResp;

    assign fetchSide.awReady = selFetch & ram.awReady;
    assign fetchSide.wReady  = selFetch & ram.wReady;
    assign fetchSide.bValid  = selFetch & ram.bValid;
    assign fetchSide.bResp   = ram.bResp;
    assign fetchSide.arReady = selFetch & ram.arReady;
    assign fetchSide.rValid  = selFetch & ram.rValid;
    assign fetchSide.rData   = ram.rData;
    assign fetchSide.rResp   = ram.rResp;

    // A response from the RAM must always have an owner to go back to.
    idleNoResponse: assert property (@(posedge clk) disable iff (rst)
        !ownerValid |-> !ram.bValid && !ram.rValid)
        else $error("busArbiter: RAM response pending with no owner");

endmodule

`default_nettype wire

//--- verilog/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
    parameter int addrWidth = 12,
    parameter int memWords  = 1024
) (
    input  logic      clk,
    input  logic      rst,
    axiLiteIf.slave   bus
);

    localparam int indexWidth = addrWidth - 2;

    logic [memPkg::dataWidth-1:0]  mem [memWords];
    logic [indexWidth-1:0]         wIndex;
    logic [indexWidth-1:0]         rIndex;
    logic                          wInRange;
    logic                          rInRange;
    logic                          writeAccept;
    logic                          readAccept;

    assign wIndex   = bus.awAddr[addrWidth-1:2];
    assign rIndex   = bus.arAddr[addrWidth-1:2];
    assign wInRange = int'(wIndex) < memWords;
    assign rInRange = int'(rIndex) < memWords;

    // Address and data are taken together, one write response at a time.
    assign writeAccept = bus.awValid && bus.wValid && !bus.bValid;
    assign readAccept  = bus.arValid && !bus.rValid;
    assign bus.awReady = writeAccept;
    assign bus.wReady  = writeAccept;
    assign bus.arReady = !bus.rValid;

    always_ff @(posedge clk)
    begin
        if (writeAccept && wInRange)
            for (int i = 0; i < memPkg::strobeWidth; i++)
                if (bus.wStrb[i])
                    mem[wIndex][i*8 +: 8] <= bus.wData[i*8 +: 8];
        if (writeAccept)
            bus.bResp <= wInRange ? memPkg::respOkay : memPkg::respSlvErr;
        if (readAccept)
        begin
            bus.rData <= rInRange ? mem[rIndex] : '0;
            bus.rResp <= rInRange ? memPkg::respOkay : memPkg::respSlvErr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            bus.bValid <= 1'b0;
            bus.rValid <= 1'b0;
        end
        else
        begin
            if (writeAccept)
                bus.bValid <= 1'b1;
            else if (bus.bReady)
                bus.bValid <= 1'b0;
            if (readAccept)
                bus.rValid <= 1'b1;
            else if (bus.rReady)
                bus.rValid <= 1'b0;
        end
    end

    bHold: assert property (@(posedge clk) disable iff (rst)
        bus.bValid && !bus.bReady |=> bus.bValid && $stable(bus.bResp))
        else $error("dataRam: write response dropped before bReady");

endmodule

`default_nettype wire

//--- verilog/memSubsystem.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystem #(
    parameter int addrWidth = 12,
    parameter int memWords  = 1024
) (
    input  logic                          clk,
    input  logic                          rst,
    // Data port.
    input  logic                          reqValid,
    output logic                          reqReady,
    input  logic                          reqWrite,
    input  memPkg::accessType             reqType,
    input  logic                          reqUnsigned,
    input  logic [addrWidth-1:0]          reqAddr,
    input  logic [memPkg::dataWidth-1:0]  reqData,
    output logic                          respValid,
    input  logic                          respReady,
    output logic [memPkg::dataWidth-1:0]  respData,
    output logic                          respError,
    // Instruction port.
    input  logic                          fetchValid,
    output logic                          fetchReady,
    input  logic [addrWidth-1:0]          fetchAddr,
    output logic                          fetchRespValid,
    input  logic                          fetchRespReady,
    output logic [memPkg::dataWidth-1:0]  fetchInstr,
    output logic                          fetchError
);

    axiLiteIf #(.addrWidth(addrWidth)) dataBus ();
    axiLiteIf #(.addrWidth(addrWidth)) fetchBus ();
    axiLiteIf #(.addrWidth(addrWidth)) ramBus ();

    memStage #(.addrWidth(addrWidth)) u_memStage (
        .clk         (clk),
        .rst         (rst),
        .reqValid    (reqValid),
        .reqReady    (reqReady),
        .reqWrite    (reqWrite),
        .reqType     (reqType),
        .reqUnsigned (reqUnsigned),
        .reqAddr     (reqAddr),
        .reqData     (reqData),
        .respValid   (respValid),
        .respReady   (respReady),
        .respData    (respData),
        .respError   (respError),
        .bus         (dataBus)
    );

    fetchPort #(.addrWidth(addrWidth)) u_fetchPort (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchReady     (fetchReady),
        .fetchAddr      (fetchAddr),
        .fetchRespValid (fetchRespValid),
        .fetchRespReady (fetchRespReady),
        .fetchInstr     (fetchInstr),
        .fetchError     (fetchError),
        .bus            (fetchBus)
    );

    busArbiter #(.addrWidth(addrWidth)) u_busArbiter (
        .clk       (clk),
        .rst       (rst),
        .dataSide  (dataBus),
        .fetchSide (fetchBus),
        .ram       (ramBus)
    );

    dataRam #(.addrWidth(addrWidth), .memWords(memWords)) u_dataRam (
        .clk (clk),
        .rst (rst),
        .bus (ramBus)
    );

endmodule

`default_nettype wire

//--- test/memSubsystemTests.svh
// ####################
// Expected values from the alignment, range, strobe and extension rules.

function automatic logic accessFails(input logic [addrWidth-1:0] a,
                                     input memPkg::accessType t);
    logic misaligned;
    case (t)
        memPkg::accByte: misaligned = 1'b0;
        memPkg::accHalf: misaligned = a[0];
        default:         misaligned = (a[1:0] != 2'b00);
    endcase
    return misaligned || (int'(a >> 2) >= memWords);
endfunction

function automatic void modelStore(input logic [addrWidth-1:0] a,
                                   input memPkg::accessType t, input logic [31:0] d);
    refMem[a] = d[7:0];
    if (t != memPkg::accByte)
        refMem[a + 12'd1] = d[15:8];
    if (t == memPkg::accWord)
    begin
        refMem[a + 12'd2] = d[23:16];
        refMem[a + 12'd3] = d[31:24];
    end
endfunction

function automatic logic [31:0] expectLoad(input logic [addrWidth-1:0] a,
                                           input memPkg::accessType t, input logic uns);
    logic [7:0]  b;
    logic [15:0] h;
    b = refMem[a];
    h = {refMem[a + 12'd1], refMem[a]};
    case (t)
        memPkg::accByte: return uns ? {24'h0, b} : {{24{b[7]}}, b};
        memPkg::accHalf: return uns ? {16'h0, h} : {{16{h[15]}}, h};
        default:         return {refMem[a + 12'd3], refMem[a + 12'd2], h};
    endcase
endfunction

// ####################
// Data port handshakes.

task automatic sendRequest(input logic write, input memPkg::accessType t, input logic uns,
                           input logic [addrWidth-1:0] a, input logic [31:0] d);
    int waited;
    reqValid    = 1'b1;
    reqWrite    = write;
    reqType     = t;
    reqUnsigned = uns;
    reqAddr     = a;
    reqData     = d;
    waited      = 0;
    while (!reqReady)
    begin
        nextCycle();
        waited++;
        if (waited > respTimeout)
            failRun("Data request was never accepted.");
    end
    nextCycle();
    reqValid = 1'b0;
endtask

task automatic awaitResponse();
    int waited;
    waited = 0;
    while (!respValid)
    begin
        nextCycle();
        waited++;
        if (waited > respTimeout)
            failRun("Data response never arrived.");
    end
endtask

task automatic takeResponse();
    respReady = 1'b1;
    nextCycle();
    respReady = 1'b0;
endtask

task automatic dataAccess(input logic write, input memPkg::accessType t, input logic uns,
                          input logic [addrWidth-1:0] a, input logic [31:0] d);
    logic        expErr;
    logic [31:0] expData;
    expErr  = accessFails(a, t);
    expData = expectLoad(a, t, uns);
    sendRequest(write, t, uns, a, d);
    awaitResponse();
    checkValue("respError", 32'(respError), 32'(expErr));
    if (!write && !expErr)
        checkValue("respData", respData, expData);
    if (write && !expErr)
        modelStore(a, t, d);
    takeResponse();
endtask

task automatic fetchCheck(input logic [addrWidth-1:0] a);
    logic        expErr;
    logic [31:0] expInstr;
    int          waited;
    expErr     = accessFails(a, memPkg::accWord);
    expInstr   = expectLoad(a, memPkg::accWord, 1'b0);
    fetchValid = 1'b1;
    fetchAddr  = a;
    waited     = 0;
    while (!fetchReady)
    begin
        nextCycle();
        waited++;
        if (waited > respTimeout)
            failRun("Fetch request was never accepted.");
    end
    nextCycle();
    fetchValid = 1'b0;
    waited     = 0;
    while (!fetchRespValid)
    begin
        nextCycle();
        waited++;
        if (waited > respTimeout)
            failRun("Fetch response never arrived.");
    end
    checkValue("fetchError", 32'(fetchError), 32'(expErr));
    if (!expErr)
        checkValue("fetchInstr", fetchInstr, expInstr);
    fetchRespReady = 1'b1;
    nextCycle();
    fetchRespReady = 1'b0;
endtask

// Both ports start in the same cycle, responses are taken as they show up.
task automatic dataAndFetch(input logic write, input logic [addrWidth-1:0] dataAddr,
                            input logic [31:0] d, input logic [addrWidth-1:0] instrAddr);
    logic        dataSeen;
    logic        fetchSeen;
    logic [31:0] expData;
    logic [31:0] expInstr;
    int          waited;
    expData  = expectLoad(dataAddr, memPkg::accWord, 1'b0);
    expInstr = expectLoad(instrAddr, memPkg::accWord, 1'b0);
    checkValue("reqReady", 32'(reqReady), 32'd1);
    checkValue("fetchReady", 32'(fetchReady), 32'd1);
    reqValid    = 1'b1;
    reqWrite    = write;
    reqType     = memPkg::accWord;
    reqUnsigned = 1'b0;
    reqAddr     = dataAddr;
    reqData     = d;
    fetchValid  = 1'b1;
    fetchAddr   = instrAddr;
    nextCycle();
    reqValid   = 1'b0;
    fetchValid = 1'b0;
    dataSeen   = 1'b0;
    fetchSeen  = 1'b0;
    waited     = 0;
    while (!(dataSeen && fetchSeen))
    begin
        if (respValid && !dataSeen)
        begin
            checkValue("respError", 32'(respError), 32'd0);
            if (!write)
                checkValue("respData", respData, expData);
            respReady = 1'b1;
            dataSeen  = 1'b1;
        end
        if (fetchRespValid && !fetchSeen)
        begin
            checkValue("fetchError", 32'(fetchError), 32'd0);
            checkValue("fetchInstr", fetchInstr, expInstr);
            fetchRespReady = 1'b1;
            fetchSeen      = 1'b1;
        end
        nextCycle();
        respReady      = 1'b0;
        fetchRespReady = 1'b0;
        waited++;
        if (waited > respTimeout)
            failRun("Concurrent data and fetch did not both complete.");
    end
    if (write)
        modelStore(dataAddr, memPkg::accWord, d);
endtask

// ####################
// Directed tests.

task automatic testWordRoundTrip();
    logic [addrWidth-1:0] addrs [randomWords];
    logic [31:0]          value;
    for (int i = 0; i < randomWords; i++)
    begin
        addrs[i] = 12'(($urandom() % memWords) * 4);
        value    = $urandom();
        dataAccess(1'b1, memPkg::accWord, 1'b0, addrs[i], value);
    end
    for (int i = 0; i < randomWords; i++)
        dataAccess(1'b0, memPkg::accWord, 1'b0, addrs[i], 32'h0);
endtask

task automatic testLaneStores();
    logic [addrWidth-1:0] base;
    base = 12'h040;
    for (int lane = 0; lane < 4; lane++)
    begin
        dataAccess(1'b1, memPkg::accWord, 1'b0, base, 32'h11223344);
        dataAccess(1'b1, memPkg::accByte, 1'b0, base + 12'(lane),
                   {24'hFFFFFF, 8'hA0 + 8'(lane)}); // Upper bits must not leak.
        dataAccess(1'b0, memPkg::accWord, 1'b0, base, 32'h0);
    end
    for (int half = 0; half < 2; half++)
    begin
        dataAccess(1'b1, memPkg::accWord, 1'b0, base, 32'h55667788);
        dataAccess(1'b1, memPkg::accHalf, 1'b0, base + 12'(half * 2), 32'hABCD9E01);
        dataAccess(1'b0, memPkg::accWord, 1'b0, base, 32'h0);
    end
endtask

task automatic testLoadExtension();
    logic [addrWidth-1:0] base;
    base = 12'h080;
    dataAccess(1'b1, memPkg::accWord, 1'b0, base, 32'hF0A5C396); // Every byte negative.
    for (int lane = 0; lane < 4; lane++)
    begin
        dataAccess(1'b0, memPkg::accByte, 1'b0, base + 12'(lane), 32'h0);
        dataAccess(1'b0, memPkg::accByte, 1'b1, base + 12'(lane), 32'h0);
    end
    for (int half = 0; half < 2; half++)
    begin
        dataAccess(1'b0, memPkg::accHalf, 1'b0, base + 12'(half * 2), 32'h0);
        dataAccess(1'b0, memPkg::accHalf, 1'b1, base + 12'(half * 2), 32'h0);
    end
endtask

task automatic testErrorCases();
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h000, 32'h0BADF00D);
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h100, 32'h76543210);
    // Misaligned halves and words around 0x100.
    dataAccess(1'b1, memPkg::accHalf, 1'b0, 12'h101, 32'h0000FFFF);
    dataAccess(1'b1, memPkg::accHalf, 1'b0, 12'h103, 32'h0000EEEE);
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h102, 32'hFFFFFFFF);
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h101, 32'hDDDDDDDD);
    dataAccess(1'b0, memPkg::accHalf, 1'b1, 12'h101, 32'h0);
    dataAccess(1'b0, memPkg::accWord, 1'b0, 12'h103, 32'h0);
    // Beyond the last word.
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'hC00, 32'h12345678);
    dataAccess(1'b1, memPkg::accByte, 1'b0, 12'hFFF, 32'h000000AA);
    dataAccess(1'b0, memPkg::accWord, 1'b0, 12'hC00, 32'h0);
    fetchCheck(12'h102);
    fetchCheck(12'hC04);
    dataAccess(1'b0, memPkg::accWord, 1'b0, 12'h000, 32'h0);
    dataAccess(1'b0, memPkg::accWord, 1'b0, 12'h100, 32'h0);
endtask

task automatic testConcurrentFetch();
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h200, 32'h27BDFFE0);
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h204, 32'hAFBF001C);
    dataAccess(1'b1, memPkg::accWord, 1'b0, 12'h300, 32'h13572468);
    dataAndFetch(1'b0, 12'h300, 32'h0, 12'h200);
    dataAndFetch(1'b1, 12'h304, 32'h9ABCDEF0, 12'h204);
    dataAndFetch(1'b0, 12'h304, 32'h0, 12'h200);
    fetchCheck(12'h204);
endtask

task automatic testBackPressure();
    logic [addrWidth-1:0] a;
    logic [31:0]          held;
    a = 12'h2A0;
    dataAccess(1'b1, memPkg::accWord, 1'b0, a, $urandom());
    sendRequest(1'b0, memPkg::accWord, 1'b0, a, 32'h0);
    awaitResponse();
    held = respData;
    repeat (6)
    begin
        nextCycle();
        checkValue("respValid", 32'(respValid), 32'd1);
        checkValue("respData", respData, held);
        checkValue("reqReady", 32'(reqReady), 32'd0);
    end
    checkValue("respError", 32'(respError), 32'd0);
    checkValue("respData", respData, expectLoad(a, memPkg::accWord, 1'b0));
    takeResponse();
    checkValue("reqReady", 32'(reqReady), 32'd1);
endtask

//--- test/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb;

    localparam int addrWidth   = 12;
    localparam int memWords    = 768;  // Top quarter of the byte space is out of range.
    localparam int clkPeriod   = 10;
    localparam int randomWords = 16;
    localparam int txnCount    = 2 * randomWords + 80; // Upper bound over all tests.
    localparam int txnCycles   = 20;
    localparam int respTimeout = 40;
    localparam int watchdogNs  = (txnCount * txnCycles + 50) * clkPeriod;

    logic                          clk;
    logic                          rst;
    logic                          reqValid;
    logic                          reqReady;
    logic                          reqWrite;
    memPkg::accessType             reqType;
    logic                          reqUnsigned;
    logic [addrWidth-1:0]          reqAddr;
    logic [memPkg::dataWidth-1:0]  reqData;
    logic                          respValid;
    logic                          respReady;
    logic [memPkg::dataWidth-1:0]  respData;
    logic                          respError;
    logic                          fetchValid;
    logic                          fetchReady;
    logic [addrWidth-1:0]          fetchAddr;
    logic                          fetchRespValid;
    logic                          fetchRespReady;
    logic [memPkg::dataWidth-1:0]  fetchInstr;
    logic                          fetchError;

    // Byte image of the RAM, little-endian lanes.
    logic [7:0] refMem [1 << addrWidth];

    memSubsystem #(.addrWidth(addrWidth), .memWords(memWords)) u_memSubsystem (
        .clk            (clk),
        .rst            (rst),
        .reqValid       (reqValid),
        .reqReady       (reqReady),
        .reqWrite       (reqWrite),
        .reqType        (reqType),
        .reqUnsigned    (reqUnsigned),
        .reqAddr        (reqAddr),
        .reqData        (reqData),
        .respValid      (respValid),
        .respReady      (respReady),
        .respData       (respData),
        .respError      (respError),
        .fetchValid     (fetchValid),
        .fetchReady     (fetchReady),
        .fetchAddr      (fetchAddr),
        .fetchRespValid (fetchRespValid),
        .fetchRespReady (fetchRespReady),
        .fetchInstr     (fetchInstr),
        .fetchError     (fetchError)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // ####################
    task automatic failRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
            failRun($sformatf("FAIL at %0t ns: %s is %h, expected %h",
                              $time, name, actual, expected));
    endtask

    // Inputs change 1 ns after the rising edge.
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    initial
    begin
        #(watchdogNs);
        failRun("Watchdog expired: the tests did not finish in time.");
    end

    `include "memSubsystemTests.svh"

    // ####################
    initial
    begin
        void'($urandom(32'h060a7f6b));
        rst            = 1'b1;
        reqValid       = 1'b0;
        reqWrite       = 1'b0;
        reqType        = memPkg::accWord;
        reqUnsigned    = 1'b0;
        reqAddr        = '0;
        reqData        = '0;
        respReady      = 1'b0;
        fetchValid     = 1'b0;
        fetchAddr      = '0;
        fetchRespReady = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        checkValue("reqReady", 32'(reqReady), 32'd1);
        checkValue("fetchReady", 32'(fetchReady), 32'd1);
        checkValue("respValid", 32'(respValid), 32'd0);
        checkValue("fetchRespValid", 32'(fetchRespValid), 32'd0);

        testWordRoundTrip();
        testLaneStores();
        testLoadExtension();
        testErrorCases();
        testConcurrentFetch();
        testBackPressure();

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
verilog/memPkg.sv
verilog/axiLiteIf.sv
verilog/memStage.sv
verilog/fetchPort.sv
verilog/busArbiter.sv
verilog/dataRam.sv
verilog/memSubsystem.sv
+incdir+test
test/memSubsystemTb.sv

//--- Makefile
TOP := memSubsystemTb

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir -o simv
	./obj_dir/simv

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir

.PHONY: all run lint clean
